// File: hdl/sata_prim_pkg.sv
// SATA line encoding constants
// dword and control-flag types, 8b/10b symbols and the primitives used in bring-up

`default_nettype none

package sata_prim_pkg;

    // ------------------------------
    // basic types
    // ------------------------------
    typedef logic [31:0] dword_t;   // one transmit or receive dword
    typedef logic [3:0]  kflag_t;   // control flag per byte, bit 0 = lowest byte
    typedef logic [7:0]  symbol_t;  // one decoded 8b/10b character

    // ------------------------------
    // 8b/10b characters
    // ------------------------------
    localparam symbol_t K28_5 = 8'hBC;  // comma, leads ALIGN
    localparam symbol_t K28_3 = 8'h7C;  // leads every other primitive
    localparam symbol_t D10_2 = 8'h4A;
    localparam symbol_t D27_3 = 8'h7B;
    localparam symbol_t D21_4 = 8'h95;
    localparam symbol_t D21_5 = 8'hB5;

    // ------------------------------
    // primitives, first byte in the low lane
    // ------------------------------
    localparam dword_t ALIGN_PRIM = {D27_3, D10_2, D10_2, K28_5};
    localparam dword_t SYNC_PRIM  = {D21_5, D21_5, D21_4, K28_3};

    // dial pattern, plain data with no control char
    localparam dword_t DIAL_DATA  = {4{D10_2}};

    // primitives only ever carry K in byte 0
    localparam kflag_t KFLAG_PRIM = 4'b0001;
    localparam kflag_t KFLAG_DATA = 4'b0000;

endpackage : sata_prim_pkg

`default_nettype wire

// File: hdl/sata_link_pkg.sv
// SATA link bring-up types
// generation codes, FSM states, transmit modes and the port bundles

`default_nettype none

package sata_link_pkg;

    import sata_prim_pkg::*;

    // generation code, same encoding as the transceiver reconfig port
    typedef logic [1:0] sata_gen_t;

    localparam sata_gen_t GEN_NONE = 2'd0;
    localparam sata_gen_t GEN1     = 2'd1;  // 1.5 Gb/s
    localparam sata_gen_t GEN2     = 2'd2;  // 3.0 Gb/s
    localparam sata_gen_t GEN3     = 2'd3;  // 6.0 Gb/s

    // ------------------------------
    // bring-up FSM
    // ------------------------------
    typedef enum logic [3:0] {
        st_idle,
        st_send_comreset,
        st_hold_comreset,   // OOB coder still busy
        st_wait_cominit,
        st_send_comwake,
        st_hold_comwake,
        st_wait_comwake,
        st_wait_oobfinish,
        st_dial,            // D10.2 until the device answers with ALIGN
        st_request_recfg,
        st_wait_recfg,
        st_send_align,
        st_link_ready
    } link_state_t;

    // what the output stage puts on the line
    typedef enum logic [1:0] {
        TXM_IDLE,
        TXM_DIAL,
        TXM_ALIGN,
        TXM_READY
    } tx_mode_t;

    // ------------------------------
    // port bundles
    // ------------------------------
    typedef struct packed {
        dword_t     data;
        kflag_t     k;
        logic [3:0] syncstatus;     // word sync per byte lane
        logic       signaldetect;
    } rx_word_t;

    typedef struct packed {
        logic cominit;
        logic comwake;
        logic oobfinish;
    } oob_rx_t;

    typedef struct packed {
        logic comreset;
        logic comwake;
    } oob_cmd_t;

    typedef struct packed {
        logic is_align;
        logic is_sync;
        logic healthy;  // signal present and all lanes in sync
    } rx_class_t;

    typedef struct packed {
        logic      request;
        sata_gen_t target;
    } recfg_t;

    typedef struct packed {
        dword_t data;
        kflag_t k;
    } tx_word_t;

endpackage : sata_link_pkg

`default_nettype wire

// File: hdl/sata_rx_prim_decoder.sv
// SATA receive primitive decoder
// classifies each received dword as ALIGN, SYNC or healthy, one cycle later

`timescale 1ns/1ns
`default_nettype none

module sata_rx_prim_decoder
    import sata_prim_pkg::*;
    import sata_link_pkg::*;
(
    input  wire logic tx_reset,     // clock
    input  wire logic tx_clk,       // async reset, active high
    input  wire rx_word_t  i_rx_word,
    output rx_class_t      o_rx_class
);

    // ------------------------------
    // combinational match
    // ------------------------------
    logic lanes_synced;
    logic k_is_prim;
    logic data_align;
    logic data_sync;

    assign lanes_synced = &i_rx_word.syncstatus;    // every byte lane locked
    assign k_is_prim    = (i_rx_word.k == KFLAG_PRIM);
    assign data_align   = (i_rx_word.data == ALIGN_PRIM);
    assign data_sync    = (i_rx_word.data == SYNC_PRIM);

    // ------------------------------
    // class register
    // ------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            o_rx_class <= '0;
        end else begin
            // ALIGN only counts once word sync is reached on all lanes
            o_rx_class.is_align <= data_align && k_is_prim && lanes_synced;
            o_rx_class.is_sync  <= data_sync && k_is_prim;
            o_rx_class.healthy  <= i_rx_word.signaldetect && lanes_synced;
        end
    end

    // ALIGN and SYNC patterns must stay distinct for the FSM to work
    a_align_sync_exclusive : assert property (
        @(posedge tx_reset) disable iff (tx_clk)
        !(o_rx_class.is_align && o_rx_class.is_sync)
    );

endmodule : sata_rx_prim_decoder

`default_nettype wire

// File: hdl/sata_link_fsm.sv
// SATA link bring-up FSM
// OOB handshake, dial and ALIGN exchange, timeouts and generation stepping
// all outputs registered from the next state

`timescale 1ns/1ns
`default_nettype none

module sata_link_fsm
    import sata_link_pkg::*;
#(
    parameter int unsigned TIMEOUT_CYCLES = 132000  // per-state wait limit
) (
    input  wire logic      tx_reset,        // clock
    input  wire logic      tx_clk,          // async reset, active high
    input  wire logic      i_locked_to_ref,
    input  wire oob_rx_t   i_oob_rx,
    input  wire logic      i_oob_sent,      // commanded burst finished
    input  wire rx_class_t i_rx_class,
    output oob_cmd_t       o_oob_cmd,
    output recfg_t         o_recfg,
    output tx_mode_t       o_tx_mode,
    output sata_gen_t      o_cur_gen
);

    localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    link_state_t        state;
    link_state_t        state_next;
    logic [CNT_W-1:0]   timeout_cnt;
    logic               timed_state;
    logic               timed_out;

    // step down one generation, GEN1 wraps to GEN3
    function automatic sata_gen_t next_gen(input sata_gen_t gen);
        case (gen)
            GEN3:    return GEN2;
            GEN2:    return GEN1;
            default: return GEN3;
        endcase
    endfunction

    function automatic tx_mode_t mode_of(input link_state_t st);
        case (st)
            st_dial:       return TXM_DIAL;
            st_send_align: return TXM_ALIGN;
            st_link_ready: return TXM_READY;
            default:       return TXM_IDLE;
        endcase
    endfunction

    // ------------------------------
    // timeout counter
    // ------------------------------
    assign timed_state = state inside {st_wait_cominit, st_wait_comwake, st_wait_oobfinish,
                                       st_dial, st_wait_recfg, st_send_align};
    assign timed_out   = (timeout_cnt == CNT_W'(TIMEOUT_CYCLES));

    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            timeout_cnt <= '0;
        end else if ((state_next != state) || !timed_state) begin
            timeout_cnt <= '0;                  // restart on every state change
        end else begin
            timeout_cnt <= timeout_cnt + 1'b1;
        end
    end

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (i_locked_to_ref) begin
                    state_next = st_send_comreset;
                end
            end
            st_send_comreset: state_next = st_hold_comreset;
            st_hold_comreset: begin
                if (i_oob_sent) begin
                    state_next = st_wait_cominit;
                end
            end
            st_wait_cominit: begin
                if (i_oob_rx.cominit) begin
                    state_next = st_send_comwake;
                end else if (timed_out) begin
                    state_next = st_idle;       // no device answered
                end
            end
            st_send_comwake: state_next = st_hold_comwake;
            st_hold_comwake: begin
                if (i_oob_sent) begin
                    state_next = st_wait_comwake;
                end
            end
            st_wait_comwake: begin
                if (i_oob_rx.comwake) begin
                    state_next = st_wait_oobfinish;
                end else if (timed_out) begin
                    state_next = st_idle;
                end
            end
            st_wait_oobfinish: begin
                if (i_oob_rx.oobfinish) begin
                    state_next = st_dial;
                end else if (timed_out) begin
                    state_next = st_idle;
                end
            end
            st_dial: begin
                if (i_rx_class.is_align) begin
                    state_next = st_send_align;
                end else if (timed_out) begin
                    state_next = st_request_recfg;  // speed not supported, fall back
                end
            end
            st_request_recfg: state_next = st_wait_recfg;
            st_wait_recfg: begin
                if (timed_out) begin
                    state_next = st_idle;       // transceiver settled, retry OOB
                end
            end
            st_send_align: begin
                if (i_rx_class.is_sync) begin
                    state_next = st_link_ready;
                end else if (timed_out) begin
                    state_next = st_idle;
                end
            end
            st_link_ready: begin
                if (!i_rx_class.healthy) begin
                    state_next = st_idle;       // lost signal or word sync
                end
            end
            default: state_next = st_idle;
        endcase
    end

    // ------------------------------
    // state and output registers
    // ------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            state     <= st_idle;
            o_oob_cmd <= '0;
            o_recfg   <= '0;
            o_tx_mode <= TXM_IDLE;
            o_cur_gen <= GEN3;      // always try the fastest rate first
        end else begin
            state              <= state_next;
            o_oob_cmd.comreset <= (state_next == st_send_comreset);
            o_oob_cmd.comwake  <= (state_next == st_send_comwake);
            o_recfg.request    <= (state_next == st_request_recfg);
            o_recfg.target     <= next_gen(o_cur_gen);  // valid with request
            o_tx_mode          <= mode_of(state_next);
            if (state == st_request_recfg) begin
                o_cur_gen <= next_gen(o_cur_gen);
            end
        end
    end

    // OOB commands are single-cycle strobes, hold states sit between them
    a_oob_cmd_single : assert property (
        @(posedge tx_reset) disable iff (tx_clk)
        (|o_oob_cmd) |=> !(|o_oob_cmd)
    );

endmodule : sata_link_fsm

`default_nettype wire

// File: hdl/sata_link_output.sv
// SATA transmit output stage
// dial and ALIGN insertion into transmit data, tx_ready, linkup and generation report

`timescale 1ns/1ns
`default_nettype none

module sata_link_output
    import sata_prim_pkg::*;
    import sata_link_pkg::*;
#(
    parameter int unsigned ALIGN_WINDOW = 256,  // dwords per ALIGN pair
    parameter int unsigned LINKUP_DELAY = 9     // settling cycles before linkup
) (
    input  wire logic      tx_reset,    // clock
    input  wire logic      tx_clk,      // async reset, active high
    input  wire tx_mode_t  i_tx_mode,
    input  wire sata_gen_t i_cur_gen,
    input  wire tx_word_t  i_tx_word,
    output tx_word_t       o_tx_word,
    output logic           o_tx_ready,
    output logic           o_linkup,
    output sata_gen_t      o_sata_gen
);

    localparam int unsigned WIN_W = $clog2(ALIGN_WINDOW);
    localparam int unsigned LNK_W = $clog2(LINKUP_DELAY + 1);

    logic [WIN_W-1:0] win_cnt;
    logic [LNK_W-1:0] linkup_cnt;
    logic             mode_ready;
    logic             align_slot;
    logic             link_settled;
    logic             pass_data;

    assign mode_ready   = (i_tx_mode == TXM_READY);
    assign align_slot   = mode_ready && (win_cnt < WIN_W'(2));  // first two of each window
    assign link_settled = (linkup_cnt == LNK_W'(LINKUP_DELAY));
    assign pass_data    = mode_ready && !align_slot && link_settled;

    // ------------------------------
    // counters
    // ------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            win_cnt    <= '0;
            linkup_cnt <= '0;
        end else if (mode_ready) begin
            if (win_cnt == WIN_W'(ALIGN_WINDOW - 1)) begin
                win_cnt <= '0;
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
            if (!link_settled) begin
                linkup_cnt <= linkup_cnt + 1'b1;    // saturates at LINKUP_DELAY
            end
        end else begin
            win_cnt    <= '0;
            linkup_cnt <= '0;
        end
    end

    // ------------------------------
    // transmit word and status
    // ------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            o_tx_word  <= '0;
            o_tx_ready <= 1'b0;
            o_linkup   <= 1'b0;
        end else begin
            if (i_tx_mode == TXM_DIAL) begin
                o_tx_word <= '{data: DIAL_DATA, k: KFLAG_DATA};
            end else if (pass_data) begin
                o_tx_word <= i_tx_word;
            end else begin
                o_tx_word <= '{data: ALIGN_PRIM, k: KFLAG_PRIM};    // idle, align phase, slots
            end
            o_tx_ready <= pass_data;        // marks user data in o_tx_word
            o_linkup   <= mode_ready && link_settled;
        end
    end

    // generation only reported with the link up
    assign o_sata_gen = o_linkup ? i_cur_gen : GEN_NONE;

    // user data never leaves before linkup is reported
    a_ready_needs_linkup : assert property (
        @(posedge tx_reset) disable iff (tx_clk)
        !o_linkup |-> !o_tx_ready
    );

endmodule : sata_link_output

`default_nettype wire

// File: hdl/sata_phy_ctrl_top.sv
// SATA PHY link controller top
// receive decoder, bring-up FSM and transmit output stage in one clock domain

`timescale 1ns/1ns
`default_nettype none

module sata_phy_ctrl_top
    import sata_link_pkg::*;
#(
    parameter int unsigned TIMEOUT_CYCLES = 132000, // 880 us at 150 MHz
    parameter int unsigned ALIGN_WINDOW   = 256,
    parameter int unsigned LINKUP_DELAY   = 9
) (
    input  wire logic      tx_reset,        // clock
    input  wire logic      tx_clk,          // async reset, active high
    // receive side
    input  wire rx_word_t  i_rx_word,
    input  wire logic      i_locked_to_ref,
    input  wire oob_rx_t   i_oob_rx,
    input  wire logic      i_oob_sent,
    // OOB coder and reconfig
    output oob_cmd_t       o_oob_cmd,
    output recfg_t         o_recfg,
    // transmit side
    input  wire tx_word_t  i_tx_word,
    output tx_word_t       o_tx_word,
    output logic           o_tx_ready,
    output logic           o_linkup,
    output sata_gen_t      o_sata_gen
);

    rx_class_t rx_class;    // decoder to FSM
    tx_mode_t  tx_mode;     // FSM to output stage
    sata_gen_t cur_gen;

    sata_rx_prim_decoder u_decode (
        .tx_reset   (tx_reset),
        .tx_clk     (tx_clk),
        .i_rx_word  (i_rx_word),
        .o_rx_class (rx_class)
    );

    sata_link_fsm #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_fsm (
        .tx_reset        (tx_reset),
        .tx_clk          (tx_clk),
        .i_locked_to_ref (i_locked_to_ref),
        .i_oob_rx        (i_oob_rx),
        .i_oob_sent      (i_oob_sent),
        .i_rx_class      (rx_class),
        .o_oob_cmd       (o_oob_cmd),
        .o_recfg         (o_recfg),
        .o_tx_mode       (tx_mode),
        .o_cur_gen       (cur_gen)
    );

    sata_link_output #(
        .ALIGN_WINDOW (ALIGN_WINDOW),
        .LINKUP_DELAY (LINKUP_DELAY)
    ) u_output (
        .tx_reset   (tx_reset),
        .tx_clk     (tx_clk),
        .i_tx_mode  (tx_mode),
        .i_cur_gen  (cur_gen),
        .i_tx_word  (i_tx_word),
        .o_tx_word  (o_tx_word),
        .o_tx_ready (o_tx_ready),
        .o_linkup   (o_linkup),
        .o_sata_gen (o_sata_gen)
    );

endmodule : sata_phy_ctrl_top

`default_nettype wire

// File: sim/tb_sata_phy_ctrl.sv
// SATA PHY link controller testbench
// directed tests for OOB bring-up, ALIGN insertion, generation fallback and link loss

`timescale 1ns/1ns
`default_nettype none

module tb_sata_phy_ctrl
    import sata_prim_pkg::*;
    import sata_link_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 64;
    localparam int ALIGN_WINDOW   = 32;
    localparam int LINKUP_DELAY   = 9;
    localparam int CLK_PERIOD_NS  = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_TESTS      = 6;
    localparam int WATCHDOG_NS    = NUM_TESTS * 20 * TIMEOUT_CYCLES * CLK_PERIOD_NS;
    localparam int STREAM_CYCLES  = 4 * ALIGN_WINDOW;

    // probe selectors for wait_signal
    localparam int SIG_COMRESET = 0;
    localparam int SIG_COMWAKE  = 1;
    localparam int SIG_RECFG    = 2;
    localparam int SIG_LINKUP   = 3;
    localparam int SIG_LINKDOWN = 4;
    localparam int SIG_DIAL_END = 5;

    localparam tx_word_t ALIGN_WORD = '{data: ALIGN_PRIM, k: KFLAG_PRIM};
    localparam tx_word_t DIAL_WORD  = '{data: DIAL_DATA, k: KFLAG_DATA};
    localparam oob_cmd_t CMD_NONE   = '{comreset: 1'b0, comwake: 1'b0};
    localparam oob_cmd_t CMD_RESET  = '{comreset: 1'b1, comwake: 1'b0};
    localparam oob_cmd_t CMD_WAKE   = '{comreset: 1'b0, comwake: 1'b1};
    localparam oob_rx_t  RX_COMINIT = '{cominit: 1'b1, comwake: 1'b0, oobfinish: 1'b0};
    localparam oob_rx_t  RX_COMWAKE = '{cominit: 1'b0, comwake: 1'b1, oobfinish: 1'b0};
    localparam oob_rx_t  RX_FINISH  = '{cominit: 1'b0, comwake: 1'b0, oobfinish: 1'b1};

    logic      tx_reset;            // clock
    logic      tx_clk;              // reset
    rx_word_t  i_rx_word;
    logic      i_locked_to_ref;
    oob_rx_t   i_oob_rx;
    logic      i_oob_sent;
    tx_word_t  i_tx_word;
    oob_cmd_t  o_oob_cmd;
    recfg_t    o_recfg;
    tx_word_t  o_tx_word;
    logic      o_tx_ready;
    logic      o_linkup;
    sata_gen_t o_sata_gen;

    integer seed   = 32'h3334_b8db;
    int     errors = 0;
    int     checks = 0;

    sata_phy_ctrl_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .ALIGN_WINDOW   (ALIGN_WINDOW),
        .LINKUP_DELAY   (LINKUP_DELAY)
    ) uut (
        .tx_reset        (tx_reset),
        .tx_clk          (tx_clk),
        .i_rx_word       (i_rx_word),
        .i_locked_to_ref (i_locked_to_ref),
        .i_oob_rx        (i_oob_rx),
        .i_oob_sent      (i_oob_sent),
        .o_oob_cmd       (o_oob_cmd),
        .o_recfg         (o_recfg),
        .i_tx_word       (i_tx_word),
        .o_tx_word       (o_tx_word),
        .o_tx_ready      (o_tx_ready),
        .o_linkup        (o_linkup),
        .o_sata_gen      (o_sata_gen)
    );

    initial begin
        tx_reset = 1'b0;
        forever #(CLK_PERIOD_NS / 2) tx_reset = ~tx_reset;
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_gen(input string name, input sata_gen_t got, input sata_gen_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input tx_word_t got, input tx_word_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cmd(input string name, input oob_cmd_t got, input oob_cmd_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    function automatic rx_word_t make_rx(input dword_t d, input kflag_t k, input logic sd);
        return '{data: d, k: k, syncstatus: 4'hF, signaldetect: sd};   // all lanes synced
    endfunction

    function automatic tx_word_t random_word();
        tx_word_t w;
        w.data = $random(seed);
        w.k    = kflag_t'($random(seed));
        return w;
    endfunction

    function automatic logic probe(input int which);
        case (which)
            SIG_COMRESET: return o_oob_cmd.comreset;
            SIG_COMWAKE:  return o_oob_cmd.comwake;
            SIG_RECFG:    return o_recfg.request;
            SIG_LINKUP:   return o_linkup;
            SIG_LINKDOWN: return !o_linkup;
            SIG_DIAL_END: return (o_tx_word != DIAL_WORD);
            default:      return 1'b0;
        endcase
    endfunction

    // polls at the falling edge where outputs are settled
    task automatic wait_signal(input int which, input int limit, input string what);
        int n;
        n = 0;
        @(negedge tx_reset);
        while (!probe(which) && n < limit) begin
            @(negedge tx_reset);
            n++;
        end
        if (!probe(which)) begin
            $display("timeout, %s did not happen within %0d cycles", what, limit);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge tx_reset);
        tx_clk          <= 1'b1;
        i_locked_to_ref <= 1'b0;
        i_oob_rx        <= '0;
        i_oob_sent      <= 1'b0;
        i_rx_word       <= '0;
        i_tx_word       <= '0;
        repeat (RESET_CYCLES) @(posedge tx_reset);
        tx_clk <= 1'b0;
    endtask

    task automatic pulse_oob_sent();
        @(posedge tx_reset);
        i_oob_sent <= 1'b1;
        @(posedge tx_reset);
        i_oob_sent <= 1'b0;
    endtask

    task automatic pulse_oob_rx(input oob_rx_t ev);
        @(posedge tx_reset);
        i_oob_rx <= ev;
        @(posedge tx_reset);
        i_oob_rx <= '0;
    endtask

    // lock and OOB handshake up to the dial pattern
    task automatic reach_dial(input int reset_limit);
        @(posedge tx_reset);
        i_locked_to_ref <= 1'b1;
        wait_signal(SIG_COMRESET, reset_limit, "comreset strobe");
        check_cmd("o_oob_cmd", o_oob_cmd, CMD_RESET);
        @(negedge tx_reset);
        check_cmd("o_oob_cmd", o_oob_cmd, CMD_NONE);      // single strobe
        pulse_oob_sent();
        pulse_oob_rx(RX_COMINIT);
        wait_signal(SIG_COMWAKE, 2, "comwake strobe");
        check_cmd("o_oob_cmd", o_oob_cmd, CMD_WAKE);
        pulse_oob_sent();
        pulse_oob_rx(RX_COMWAKE);
        pulse_oob_rx(RX_FINISH);
        repeat (2) @(negedge tx_reset);                  // FSM then output register
        check_word("o_tx_word", o_tx_word, DIAL_WORD);
    endtask

    // ALIGN then SYNC from the device until linkup
    task automatic finish_link(input sata_gen_t exp_gen);
        @(posedge tx_reset);
        i_rx_word <= make_rx(ALIGN_PRIM, KFLAG_PRIM, 1'b1);
        wait_signal(SIG_DIAL_END, 6, "end of the dial pattern");
        check_word("o_tx_word", o_tx_word, ALIGN_WORD);
        @(posedge tx_reset);
        i_rx_word <= make_rx(SYNC_PRIM, KFLAG_PRIM, 1'b1);
        wait_signal(SIG_LINKUP, LINKUP_DELAY + 4, "linkup");
        check_gen("o_sata_gen", o_sata_gen, exp_gen);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_reset_idle();
        int start;
        start = errors;
        apply_reset();
        repeat (3 * TIMEOUT_CYCLES) begin
            @(negedge tx_reset);
            check_cmd("o_oob_cmd", o_oob_cmd, CMD_NONE);
            check_bit("o_recfg.request", o_recfg.request, 1'b0);
            check_bit("o_linkup", o_linkup, 1'b0);
            check_gen("o_sata_gen", o_sata_gen, GEN_NONE);
        end
        finish_test("reset_idle", start);
    endtask

    task automatic test_bring_up();
        int start;
        start = errors;
        apply_reset();
        reach_dial(4);
        finish_link(GEN3);
        finish_test("bring_up", start);
    endtask

    task automatic test_align_insert();
        int       start;
        int       low_cnt;
        tx_word_t prev;
        tx_word_t word;
        logic     ready_hist [STREAM_CYCLES];
        start = errors;
        apply_reset();
        reach_dial(4);
        finish_link(GEN3);
        @(posedge tx_reset);
        prev = random_word();
        i_tx_word <= prev;
        for (int i = 0; i < STREAM_CYCLES; i++) begin
            @(posedge tx_reset);
            word = random_word();
            i_tx_word <= word;
            @(negedge tx_reset);
            ready_hist[i] = o_tx_ready;
            if (o_tx_ready) begin
                check_word("o_tx_word", o_tx_word, prev);        // accepted source word
            end else begin
                check_word("o_tx_word", o_tx_word, ALIGN_WORD);  // inserted ALIGN
            end
            prev = word;
        end
        for (int w = 0; w < STREAM_CYCLES / ALIGN_WINDOW; w++) begin
            low_cnt = 0;
            for (int j = 0; j < ALIGN_WINDOW; j++) begin
                if (!ready_hist[w * ALIGN_WINDOW + j]) begin
                    low_cnt++;
                end
            end
            checks++;
            if (low_cnt != 2) begin
                $display("window %0d holds %0d cycles with o_tx_ready low, expected 2",
                         w, low_cnt);
                errors++;
            end
        end
        finish_test("align_insert", start);
    endtask

    task automatic test_gen_fallback();
        int        start;
        sata_gen_t expected [3];
        start    = errors;
        expected = '{GEN2, GEN1, GEN3};
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            reach_dial((i == 0) ? 4 : TIMEOUT_CYCLES + 8);   // later rounds wait out recfg
            wait_signal(SIG_RECFG, TIMEOUT_CYCLES + 8, "reconfiguration request");
            check_gen("o_recfg.target", o_recfg.target, expected[i]);
            @(negedge tx_reset);
            check_bit("o_recfg.request", o_recfg.request, 1'b0);
        end
        reach_dial(TIMEOUT_CYCLES + 8);
        finish_link(expected[2]);
        finish_test("gen_fallback", start);
    endtask

    task automatic test_oob_timeout();
        int   start;
        int   n;
        logic seen;
        start = errors;
        seen  = 1'b0;
        n     = 0;
        apply_reset();
        @(posedge tx_reset);
        i_locked_to_ref <= 1'b1;
        wait_signal(SIG_COMRESET, 4, "first comreset strobe");
        pulse_oob_sent();
        // no COMINIT so a retry follows the wait limit
        while (!seen && n < TIMEOUT_CYCLES + 8) begin
            @(negedge tx_reset);
            check_bit("o_linkup", o_linkup, 1'b0);
            seen = o_oob_cmd.comreset;
            n++;
        end
        if (!seen) begin
            $display("timeout, no comreset retry after the missing COMINIT");
            errors++;
        end
        finish_test("oob_timeout", start);
    endtask

    task automatic test_link_loss();
        int start;
        start = errors;
        apply_reset();
        reach_dial(4);
        finish_link(GEN3);
        repeat (4) @(posedge tx_reset);
        i_rx_word <= make_rx(SYNC_PRIM, KFLAG_PRIM, 1'b0);   // signal gone
        wait_signal(SIG_LINKDOWN, 6, "linkup drop");
        check_bit("o_tx_ready", o_tx_ready, 1'b0);
        check_word("o_tx_word", o_tx_word, ALIGN_WORD);
        check_gen("o_sata_gen", o_sata_gen, GEN_NONE);
        finish_test("link_loss", start);
    endtask

    // ------------------------------
    // sequence and verdict
    // ------------------------------
    initial begin
        tx_clk          = 1'b1;
        i_locked_to_ref = 1'b0;
        i_oob_rx        = '0;
        i_oob_sent      = 1'b0;
        i_rx_word       = '0;
        i_tx_word       = '0;
        test_reset_idle();
        test_bring_up();
        test_align_insert();
        test_gen_fallback();
        test_oob_timeout();
        test_link_loss();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests ran longer than %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule : tb_sata_phy_ctrl

`default_nettype wire

// File: filelist.f
hdl/sata_prim_pkg.sv
hdl/sata_link_pkg.sv
hdl/sata_rx_prim_decoder.sv
hdl/sata_link_fsm.sv
hdl/sata_link_output.sv
hdl/sata_phy_ctrl_top.sv
sim/tb_sata_phy_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the SATA PHY controller testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_sata_phy_ctrl
BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module "$TOP" -Mdir "$BUILD" -f filelist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
